//--- main_ram.sv
`default_nettype none
`include "vera_params.svh"

module main_ram (
    input  wire                          clk,
    input  wire [`VERA_MAINRAM_AW-1:0]   addr_i,
    input  wire vera_pkg::mem_word_u     wrdata_i,
    input  wire [`VERA_BYTES-1:0]        bytesel_i,
    input  wire                          we_i,
    output vera_pkg::mem_word_u          rddata_o
);

    localparam int DEPTH = 1 << `VERA_MAINRAM_AW;

    // 32K words of 32 bits for 128 KB
    vera_pkg::mem_word_u mem [0:DEPTH-1];

    ////////////////////
    // Write port
    ////////////////////

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int i = 0; i < `VERA_BYTES; i++) begin
                if (bytesel_i[i]) begin
                    mem[addr_i].bytes[i] <= wrdata_i.bytes[i];
                end
            end
        end
    end

    // A write needs a known word and lane select
    write_target_known: assert property (
        @(posedge clk) we_i |-> !$isunknown({addr_i, bytesel_i})
    ) else $error("main_ram: write with unknown address or lane select");

    ////////////////////
    // Read port
    ////////////////////

    // Registered read returns old data on a same-address write
    always_ff @(posedge clk) begin
        rddata_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

//--- membus_arbiter.sv
`default_nettype none
`include "vera_params.svh"

module membus_arbiter (
    input  wire                          clk,
    input  wire                          reset,
    input  wire vera_pkg::regbus_req_t   regbus_i,
    input  wire                          mem_sel_i,
    input  wire vera_pkg::fetch_req_t    fetch_i,
    input  wire vera_pkg::mem_word_u     mem_rddata_i,
    output logic [`VERA_MAINRAM_AW-1:0]  mem_addr_o,
    output vera_pkg::mem_word_u          mem_wrdata_o,
    output logic [`VERA_BYTES-1:0]       mem_bytesel_o,
    output logic                         mem_we_o,
    output logic [`VERA_DATA_W-1:0]      mem_byte_o,
    output logic                         fetch_ack_o,
    output logic [`VERA_WORD_W-1:0]      fetch_rddata_o
);

    localparam int LANE_W = $clog2(`VERA_BYTES);

    logic              cpu_mem;
    logic              fetch_grant;
    logic [LANE_W-1:0] cpu_lane;
    logic [LANE_W-1:0] lane_q;

    ////////////////////
    // Grant
    ////////////////////

    // CPU always wins and fetch only gets idle cycles
    assign cpu_mem     = regbus_i.strobe && mem_sel_i;
    assign fetch_grant = fetch_i.strobe && !cpu_mem;
    assign cpu_lane    = regbus_i.addr[LANE_W-1:0];

    // Byte address to word address for the CPU
    always_comb begin
        if (cpu_mem) begin
            mem_addr_o = regbus_i.addr[`VERA_MAINRAM_AW+LANE_W-1:LANE_W];
        end else begin
            mem_addr_o = fetch_i.addr[`VERA_MAINRAM_AW-1:0];
        end
    end

    assign mem_we_o      = cpu_mem && regbus_i.write;
    assign mem_bytesel_o = `VERA_BYTES'(1) << cpu_lane;

    // Same byte on every lane and bytesel picks the one that lands
    always_comb begin
        for (int i = 0; i < `VERA_BYTES; i++) begin
            mem_wrdata_o.bytes[i] = regbus_i.wrdata;
        end
    end

    ////////////////////
    // Read return
    ////////////////////

    // Lane of the CPU access lined up with the RAM output
    always_ff @(posedge clk) begin
        lane_q <= cpu_lane;
    end

    assign mem_byte_o = mem_rddata_i.bytes[lane_q];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch_ack_o <= 1'b0;
        end else begin
            fetch_ack_o <= fetch_grant;
        end
    end

    assign fetch_rddata_o = mem_rddata_i.word;

    // A pending fetch stays requested until its acknowledge
    fetch_held_until_ack: assert property (
        @(posedge clk) disable iff (reset)
        fetch_i.strobe && !fetch_ack_o |=> fetch_i.strobe || fetch_ack_o
    ) else $error("membus_arbiter: fetch request dropped before its acknowledge");

endmodule

`default_nettype wire

//--- palette_block.sv
`default_nettype none
`include "vera_params.svh"

module palette_block (
    input  wire                          clk,
    input  wire vera_pkg::regbus_req_t   regbus_i,
    input  wire                          sel_i,
    input  wire [`VERA_PAL_AW-1:0]       pixel_i,
    output logic [`VERA_RGB_W-1:0]       rgb_o,
    output logic [`VERA_DATA_W-1:0]      rddata_o
);

    localparam int DEPTH = 1 << `VERA_PAL_AW;

    logic [`VERA_PAL_W-1:0]  pal_mem [0:DEPTH-1];
    logic                    pal_we;
    logic [`VERA_PAL_AW-1:0] reg_idx;
    logic                    reg_hi;
    logic [`VERA_PAL_W-1:0]  rb_entry_q;
    logic                    rb_hi_q;

    // Entry index in address bits 8:1, bit 0 picks low or high byte
    assign reg_idx = regbus_i.addr[`VERA_PAL_AW:1];
    assign reg_hi  = regbus_i.addr[0];
    assign pal_we  = sel_i && regbus_i.strobe && regbus_i.write;

    ////////////////////
    // Register writes
    ////////////////////

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_mem[reg_idx][{reg_hi, 3'b000} +: `VERA_DATA_W] <= regbus_i.wrdata;
        end
    end

    ////////////////////
    // Read ports
    ////////////////////

    // Display lookup, 4 bits each of R, G and B
    always_ff @(posedge clk) begin
        rgb_o <= pal_mem[pixel_i][`VERA_RGB_W-1:0];
    end

    // Readback follows the register address
    always_ff @(posedge clk) begin
        rb_entry_q <= pal_mem[reg_idx];
        rb_hi_q    <= reg_hi;
    end

    assign rddata_o = rb_entry_q[{rb_hi_q, 3'b000} +: `VERA_DATA_W];

endmodule

`default_nettype wire

//--- regbus_decoder.sv
`default_nettype none
`include "vera_params.svh"

module regbus_decoder (
    input  wire vera_pkg::regbus_req_t regbus_i,
    input  wire [`VERA_DATA_W-1:0]     mem_byte_i,
    input  wire [`VERA_DATA_W-1:0]     pal_byte_i,
    input  wire [`VERA_DATA_W-1:0]     spr_byte_i,
    output logic                       mem_sel_o,
    output logic                       pal_sel_o,
    output logic                       spr_sel_o,
    output logic [`VERA_DATA_W-1:0]    rddata_o
);

    // Nibble positions in the register address
    localparam int SPACE_MSB  = `VERA_REGBUS_AW - 1;
    localparam int REGION_MSB = `VERA_REGBUS_AW - 5;

    logic [3:0] space_nibble;
    logic [3:0] region_nibble;
    logic       io_space;

    ////////////////////
    // Region decode
    ////////////////////

    // Address map of the fabric
    //   00000-1FFFF main RAM
    //   F1000-F11FF palette
    //   F5000-F53FF sprite attributes
    //   other Fx000 regions are unmapped here and read as zero
    assign space_nibble  = regbus_i.addr[SPACE_MSB -: 4];
    assign region_nibble = regbus_i.addr[REGION_MSB -: 4];
    assign io_space      = (space_nibble == `VERA_REGION_IO);

    assign mem_sel_o = !io_space;
    assign pal_sel_o = io_space && (region_nibble == `VERA_REGION_PALETTE);
    assign spr_sel_o = io_space && (region_nibble == `VERA_REGION_SPRATTR);

    ////////////////////
    // Read data mux
    ////////////////////

    always_comb begin
        if (mem_sel_o) begin
            rddata_o = mem_byte_i;
        end else if (pal_sel_o) begin
            rddata_o = pal_byte_i;
        end else if (spr_sel_o) begin
            rddata_o = spr_byte_i;
        end else begin
            rddata_o = '0;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -o pipefail
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_vera_bus -o tb_vera_bus \
    && ./obj_dir/tb_vera_bus | tee sim.log \
    && ! grep -q "CHECKS FAILED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sprite_attr_block.sv
`default_nettype none
`include "vera_params.svh"

module sprite_attr_block (
    input  wire                          clk,
    input  wire vera_pkg::regbus_req_t   regbus_i,
    input  wire                          sel_i,
    input  wire [`VERA_SPR_AW-1:0]       sprite_idx_i,
    output logic [`VERA_WORD_W-1:0]      attr_o,
    output logic [`VERA_DATA_W-1:0]      rddata_o
);

    localparam int DEPTH  = 1 << `VERA_SPR_AW;
    localparam int LANE_W = $clog2(`VERA_BYTES);

    vera_pkg::mem_word_u     attr_mem [0:DEPTH-1];
    vera_pkg::mem_word_u     attr_q;
    vera_pkg::mem_word_u     rb_word_q;
    logic                    attr_we;
    logic [`VERA_SPR_AW-1:0] reg_idx;
    logic [LANE_W-1:0]       reg_lane;
    logic [LANE_W-1:0]       rb_lane_q;

    // Four bytes per sprite, index in address bits 9:2
    assign reg_idx  = regbus_i.addr[`VERA_SPR_AW+LANE_W-1:LANE_W];
    assign reg_lane = regbus_i.addr[LANE_W-1:0];
    assign attr_we  = sel_i && regbus_i.strobe && regbus_i.write;

    ////////////////////
    // Register writes
    ////////////////////

    always_ff @(posedge clk) begin
        if (attr_we) begin
            attr_mem[reg_idx].bytes[reg_lane] <= regbus_i.wrdata;
        end
    end

    ////////////////////
    // Read ports
    ////////////////////

    // Renderer side, whole attribute word
    always_ff @(posedge clk) begin
        attr_q <= attr_mem[sprite_idx_i];
    end

    assign attr_o = attr_q.word;

    // Register readback
    always_ff @(posedge clk) begin
        rb_word_q <= attr_mem[reg_idx];
        rb_lane_q <= reg_lane;
    end

    assign rddata_o = rb_word_q.bytes[rb_lane_q];

endmodule

`default_nettype wire

//--- src.f
+incdir+.
vera_pkg.sv
regbus_decoder.sv
membus_arbiter.sv
main_ram.sv
palette_block.sv
sprite_attr_block.sv
vera_bus_top.sv
tb_vera_bus.sv

//--- tb_vera_bus.sv
`default_nettype none
`include "vera_params.svh"

module tb_vera_bus;

    localparam int PERIOD     = 40;
    localparam int ACK_BUDGET = 20;
    localparam int MAIN_WORDS = 64;
    localparam int OPS        = 300;
    localparam int FETCHES    = 120;
    localparam int TOTAL_OPS  = 4 + MAIN_WORDS * 4 + 1536 + 4 * OPS + FETCHES;

    logic                    clk;
    logic                    reset;
    vera_pkg::regbus_req_t   regbus;
    vera_pkg::fetch_req_t    fetch;
    logic [`VERA_PAL_AW-1:0] pixel;
    logic [`VERA_SPR_AW-1:0] sprite_idx;
    logic [`VERA_DATA_W-1:0] reg_rddata;
    logic                    fetch_ack;
    logic [`VERA_WORD_W-1:0] fetch_rddata;
    logic [`VERA_RGB_W-1:0]  rgb;
    logic [`VERA_WORD_W-1:0] attr;

    // Byte models of main RAM, palette and sprite attributes
    logic [7:0]  main_model [0:(1<<17)-1];
    logic [7:0]  pal_model [0:511];
    logic [7:0]  spr_model [0:1023];
    logic [14:0] words_used [$];
    integer      seed;
    int          errors;

    vera_bus_top UUT (
        .clk(clk), .reset(reset), .regbus_i(regbus), .fetch_i(fetch),
        .pixel_i(pixel), .sprite_idx_i(sprite_idx), .reg_rddata_o(reg_rddata),
        .fetch_ack_o(fetch_ack), .fetch_rddata_o(fetch_rddata), .rgb_o(rgb), .attr_o(attr)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    // Memory map: main RAM below 20000, palette at F1xxx, sprites at F5xxx
    function automatic logic [7:0] model_byte(input logic [19:0] addr);
        if (addr[19:16] != 4'hF) model_byte = main_model[addr[16:0]];
        else if (addr[15:12] == 4'h1) model_byte = pal_model[addr[8:0]];
        else if (addr[15:12] == 4'h5) model_byte = spr_model[addr[9:0]];
        else model_byte = 8'h00;
    endfunction

    // Any byte of a word already written in full
    function automatic logic [19:0] main_addr();
        main_addr = {3'b000, words_used[rnd() % words_used.size()], 2'(rnd())};
    endfunction

    task automatic report(input string test, input logic [31:0] expected,
                          input logic [31:0] actual);
        errors++;
        $display("Fail %s: expected %h, actual %h", test, expected, actual);
    endtask

    ////////////////////
    // Bus operations, each starts and ends on a falling edge
    ////////////////////

    task automatic write_reg(input logic [19:0] addr, input logic [7:0] data);
        regbus = '{addr: addr, wrdata: data, strobe: 1'b1, write: 1'b1};
        if (addr[19:16] != 4'hF) main_model[addr[16:0]] = data;
        else if (addr[15:12] == 4'h1) pal_model[addr[8:0]] = data;
        else if (addr[15:12] == 4'h5) spr_model[addr[9:0]] = data;
        @(negedge clk);
        regbus.strobe = 1'b0;
    endtask

    task automatic read_check(input logic [19:0] addr, input string test);
        logic [7:0] expected;
        expected = model_byte(addr);
        regbus = '{addr: addr, wrdata: 8'h00, strobe: 1'b1, write: 1'b0};
        @(negedge clk);
        if (reg_rddata !== expected) report(test, 32'(expected), 32'(reg_rddata));
        regbus.strobe = 1'b0;
    endtask

    task automatic display_check();
        logic [15:0] entry;
        logic [31:0] word;
        pixel      = 8'(rnd());
        sprite_idx = 8'(rnd());
        entry = {pal_model[{pixel, 1'b1}], pal_model[{pixel, 1'b0}]};
        word  = {spr_model[{sprite_idx, 2'd3}], spr_model[{sprite_idx, 2'd2}],
                 spr_model[{sprite_idx, 2'd1}], spr_model[{sprite_idx, 2'd0}]};
        @(negedge clk);
        if (rgb !== entry[11:0]) report("palette rgb", 32'(entry[11:0]), 32'(rgb));
        if (attr !== word) report("sprite attr", word, attr);
    endtask

    task automatic fetch_test();
        logic [14:0] word_addr;
        logic [31:0] expected;
        logic [31:0] r;
        logic        acked;
        int          n;
        int          waited;
        for (n = 0; n < FETCHES; n++) begin
            word_addr = words_used[rnd() % words_used.size()];
            expected  = {main_model[{word_addr, 2'd3}], main_model[{word_addr, 2'd2}],
                         main_model[{word_addr, 2'd1}], main_model[{word_addr, 2'd0}]};
            fetch  = '{addr: {1'b0, word_addr}, strobe: 1'b1};
            regbus = '{addr: main_addr(), wrdata: 8'h00, strobe: 1'b0, write: 1'b0};
            acked  = 1'b0;
            waited = 0;
            while (!acked && waited < ACK_BUDGET) begin
                // CPU reads of one held address collide at random
                r = rnd();
                regbus.strobe = r[0];
                @(negedge clk);
                waited++;
                acked = (fetch_ack === 1'b1);
                if (r[0] && reg_rddata !== model_byte(regbus.addr))
                    report("cpu read during fetch", 32'(model_byte(regbus.addr)), 32'(reg_rddata));
                if (r[0] && acked) begin
                    errors++;
                    $display("Fetch acknowledge came right after a cycle the CPU owned");
                end
                if (!r[0] && !acked) begin
                    errors++;
                    $display("Fetch was not granted in a cycle without a CPU access");
                end
                if (acked && fetch_rddata !== expected) report("fetch data", expected, fetch_rddata);
            end
            fetch.strobe  = 1'b0;
            regbus.strobe = 1'b0;
            if (!acked) begin
                errors++;
                $display("No fetch acknowledge within %0d cycles for word %h", ACK_BUDGET, word_addr);
            end
            @(negedge clk);
            if (fetch_ack !== 1'b0) begin
                errors++;
                $display("Fetch acknowledge stayed high after the request ended");
            end
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        int          i;
        int          b;
        logic [31:0] r;
        seed = 32'h412e;
        errors = 0;
        clk = 1'b0;
        reset = 1'b1;
        regbus = '0;
        fetch = '0;
        pixel = '0;
        sprite_idx = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (fetch_ack !== 1'b0) begin
            errors++;
            $display("Fetch acknowledge is not low after reset");
        end
        // Whole words first, so fetches always see known data
        for (i = 0; i < MAIN_WORDS; i++) begin
            words_used.push_back(15'(rnd()));
            for (b = 0; b < 4; b++) write_reg({3'b000, words_used[i], 2'(b)}, 8'(rnd()));
        end
        for (i = 0; i < OPS; i++) begin
            r = rnd();
            if (r[0]) write_reg(main_addr(), r[15:8]);
            else read_check(main_addr(), "main ram read");
        end
        fetch_test();
        for (i = 0; i < 512; i++) write_reg(20'hF1000 + 20'(i), 8'(rnd()));
        for (i = 0; i < 1024; i++) write_reg(20'hF5000 + 20'(i), 8'(rnd()));
        for (i = 0; i < OPS; i++) begin
            r = rnd();
            case (r[2:0])
                3'd0: write_reg(20'hF1000 + 20'(r[12:4]), r[31:24]);
                3'd1: write_reg(20'hF5000 + 20'(r[13:4]), r[31:24]);
                3'd2: read_check(20'hF1000 + 20'(r[12:4]), "palette read");
                3'd3: read_check(20'hF5000 + 20'(r[13:4]), "sprite read");
                default: display_check();
            endcase
        end
        // Unmapped I/O regions, region 1 and 5 moved out of the way
        for (i = 0; i < OPS; i++) begin
            r = rnd();
            if (r[15:12] == 4'h1 || r[15:12] == 4'h5) r[15] = 1'b1;
            if (r[16]) write_reg({4'hF, r[15:0]}, r[31:24]);
            else read_check({4'hF, r[15:0]}, "unmapped read");
        end
        for (i = 0; i < OPS; i++) begin
            r = rnd();
            case (r[1:0])
                2'd0: read_check(20'hF1000 + 20'(r[12:4]), "palette reread");
                2'd1: read_check(20'hF5000 + 20'(r[13:4]), "sprite reread");
                default: read_check(main_addr(), "main ram reread");
            endcase
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(TOTAL_OPS * ACK_BUDGET * PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vera_bus_top.sv
`default_nettype none
`include "vera_params.svh"

module vera_bus_top (
    input  wire                          clk,
    input  wire                          reset,
    input  wire vera_pkg::regbus_req_t   regbus_i,
    input  wire vera_pkg::fetch_req_t    fetch_i,
    input  wire [`VERA_PAL_AW-1:0]       pixel_i,
    input  wire [`VERA_SPR_AW-1:0]       sprite_idx_i,
    output logic [`VERA_DATA_W-1:0]      reg_rddata_o,
    output logic                         fetch_ack_o,
    output logic [`VERA_WORD_W-1:0]      fetch_rddata_o,
    output logic [`VERA_RGB_W-1:0]       rgb_o,
    output logic [`VERA_WORD_W-1:0]      attr_o
);

    // Region selects
    logic mem_sel;
    logic pal_sel;
    logic spr_sel;

    // Readback bytes
    logic [`VERA_DATA_W-1:0] mem_byte;
    logic [`VERA_DATA_W-1:0] pal_byte;
    logic [`VERA_DATA_W-1:0] spr_byte;

    // Memory bus
    logic [`VERA_MAINRAM_AW-1:0] mem_addr;
    vera_pkg::mem_word_u         mem_wrdata;
    vera_pkg::mem_word_u         mem_rddata;
    logic [`VERA_BYTES-1:0]      mem_bytesel;
    logic                        mem_we;

    ////////////////////
    // Register bus
    ////////////////////

    regbus_decoder u_decoder (
        .regbus_i   (regbus_i),
        .mem_byte_i (mem_byte),
        .pal_byte_i (pal_byte),
        .spr_byte_i (spr_byte),
        .mem_sel_o  (mem_sel),
        .pal_sel_o  (pal_sel),
        .spr_sel_o  (spr_sel),
        .rddata_o   (reg_rddata_o)
    );

    palette_block u_palette (
        .clk      (clk),
        .regbus_i (regbus_i),
        .sel_i    (pal_sel),
        .pixel_i  (pixel_i),
        .rgb_o    (rgb_o),
        .rddata_o (pal_byte)
    );

    sprite_attr_block u_sprite_attr (
        .clk          (clk),
        .regbus_i     (regbus_i),
        .sel_i        (spr_sel),
        .sprite_idx_i (sprite_idx_i),
        .attr_o       (attr_o),
        .rddata_o     (spr_byte)
    );

    ////////////////////
    // Memory bus
    ////////////////////

    membus_arbiter u_arbiter (
        .clk            (clk),
        .reset          (reset),
        .regbus_i       (regbus_i),
        .mem_sel_i      (mem_sel),
        .fetch_i        (fetch_i),
        .mem_rddata_i   (mem_rddata),
        .mem_addr_o     (mem_addr),
        .mem_wrdata_o   (mem_wrdata),
        .mem_bytesel_o  (mem_bytesel),
        .mem_we_o       (mem_we),
        .mem_byte_o     (mem_byte),
        .fetch_ack_o    (fetch_ack_o),
        .fetch_rddata_o (fetch_rddata_o)
    );

    main_ram u_main_ram (
        .clk       (clk),
        .addr_i    (mem_addr),
        .wrdata_i  (mem_wrdata),
        .bytesel_i (mem_bytesel),
        .we_i      (mem_we),
        .rddata_o  (mem_rddata)
    );

endmodule

`default_nettype wire

//--- vera_params.svh
`ifndef VERA_PARAMS_SVH
`define VERA_PARAMS_SVH

// Register bus
`define VERA_REGBUS_AW 20
`define VERA_DATA_W 8

// Memory bus
`define VERA_WORD_W 32
`define VERA_BYTES 4
`define VERA_MAINRAM_AW 15
`define VERA_FETCH_AW 16

// Palette and sprite attribute storage
`define VERA_PAL_AW 8
`define VERA_PAL_W 16
`define VERA_RGB_W 12
`define VERA_SPR_AW 8

// Region codes, top nibble then second nibble of the register address
`define VERA_REGION_IO 4'hF
`define VERA_REGION_PALETTE 4'h1
`define VERA_REGION_SPRATTR 4'h5

`endif

//--- vera_pkg.sv
`default_nettype none
`include "vera_params.svh"

package vera_pkg;

    // One register bus access, strobe is a single-cycle pulse
    typedef struct packed {
        logic [`VERA_REGBUS_AW-1:0] addr;
        logic [`VERA_DATA_W-1:0]    wrdata;
        logic                       strobe;
        logic                       write;
    } regbus_req_t;

    // Word fetch from a renderer style master
    typedef struct packed {
        logic [`VERA_FETCH_AW-1:0] addr;
        logic                      strobe;
    } fetch_req_t;

    // Memory word, seen whole or as byte lanes (lane 0 is bits 7:0)
    typedef union packed {
        logic [`VERA_WORD_W-1:0]                  word;
        logic [`VERA_BYTES-1:0][`VERA_DATA_W-1:0] bytes;
    } mem_word_u;

endpackage

`default_nettype wire
